// ==== rtl/core_pkg.sv ====
package core_pkg;

  localparam int xlen    = 32;
  localparam int imem_aw = 8;
  localparam int dmem_aw = 8;

  // addi x0, x0, 0
  localparam logic [31:0] nop_instr = 32'h0000_0013;

  // rv32i major opcodes
  localparam logic [6:0] op_lui    = 7'b0110111;
  localparam logic [6:0] op_imm    = 7'b0010011;
  localparam logic [6:0] op_reg    = 7'b0110011;
  localparam logic [6:0] op_load   = 7'b0000011;
  localparam logic [6:0] op_store  = 7'b0100011;
  localparam logic [6:0] op_branch = 7'b1100011;

  typedef enum logic [2:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_slt,
    alu_passb
  } alu_op_e;

  ////////////////////
  // pipeline registers
  ////////////////////

  typedef struct packed {
    logic [xlen-1:0] pc;
    logic [31:0]     instr;
    logic            valid;
  } if_id_t;

  typedef struct packed {
    logic [xlen-1:0] pc;
    logic [xlen-1:0] rs1_val;
    logic [xlen-1:0] rs2_val;
    logic [4:0]      rs1;
    logic [4:0]      rs2;
    logic [4:0]      rd;
    logic [xlen-1:0] imm;
    alu_op_e         alu_op;
    logic            alu_src_imm;
    logic            mem_read;
    logic            mem_write;
    logic            reg_write;
    logic            branch;
    logic            branch_ne;
    logic            valid;
  } id_ex_t;

  typedef struct packed {
    logic [xlen-1:0] alu_res;
    logic [xlen-1:0] store_data;
    logic [4:0]      rd;
    logic            mem_read;
    logic            mem_write;
    logic            reg_write;
    logic            valid;
  } ex_mem_t;

  // also the regfile write port
  typedef struct packed {
    logic            we;
    logic [4:0]      rd;
    logic [xlen-1:0] data;
  } wb_t;

  ////////////////////
  // wishbone classic
  ////////////////////

  typedef struct packed {
    logic               cyc;
    logic               stb;
    logic               we;
    logic [dmem_aw-1:0] adr;
    logic [xlen-1:0]    dat;
  } wb_req_t;

  typedef struct packed {
    logic            ack;
    logic [xlen-1:0] dat;
  } wb_rsp_t;

endpackage

// ==== rtl/pipe_reg.sv ====
`timescale 1ns/1ps

module pipe_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     arst_n,
  input  logic     hold,
  input  logic     flush,
  input  payload_t d,
  output payload_t q
);

  // flush beats hold, a flushed stage becomes a bubble
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      q <= '0;
    end else if (flush) begin
      q <= '0;
    end else if (!hold) begin
      q <= d;
    end
  end

  a_hold_keeps_q: assert property (
    @(posedge clk) disable iff (!arst_n)
    (hold && !flush) |=> $stable(q)
  ) else $error("pipeline register changed while held");

endmodule

// ==== rtl/fetch_stage.sv ====
`timescale 1ns/1ps

module fetch_stage
  import core_pkg::*;
(
  input  logic               clk,
  input  logic               arst_n,
  input  logic               hold,
  input  logic               prog,
  input  logic               prog_we,
  input  logic [imem_aw-1:0] prog_addr,
  input  logic [xlen-1:0]    prog_data,
  input  logic               branch_taken,
  input  logic [xlen-1:0]    branch_target,
  output if_id_t             if_id,
  output logic [xlen-1:0]    prog_rdata
);

  logic [xlen-1:0] imem [2**imem_aw];
  logic [xlen-1:0] pc;
  logic            prog_q;

  // program load port
  always_ff @(posedge clk) begin
    if (prog && prog_we) begin
      imem[prog_addr] <= prog_data;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      prog_q <= 1'b0;
      pc     <= '0;
    end else begin
      prog_q <= prog;
      // restart from 0 when prog falls
      if (prog_q && !prog) begin
        pc <= '0;
      end else if (branch_taken) begin
        pc <= branch_target;
      end else if (!hold) begin
        pc <= pc + xlen'(4);
      end
    end
  end

  // word fetched on the prog falling edge comes from the stale pc
  always_comb begin
    if_id.pc    = pc;
    if_id.instr = imem[pc[imem_aw+1:2]];
    if_id.valid = !(prog || prog_q);
  end

  assign prog_rdata = imem[prog_addr];

endmodule

// ==== rtl/regfile.sv ====
`timescale 1ns/1ps

module regfile
  import core_pkg::*;
(
  input  logic            clk,
  input  logic            arst_n,
  input  logic [4:0]      rs1_addr,
  input  logic [4:0]      rs2_addr,
  output logic [xlen-1:0] rs1_data,
  output logic [xlen-1:0] rs2_data,
  input  wb_t             wb,
  input  logic [4:0]      dbg_addr,
  output logic [xlen-1:0] dbg_data
);

  logic [xlen-1:0] regs [32];

  // x0 reads zero, same-cycle write is bypassed
  function automatic logic [xlen-1:0] read_port(logic [4:0] addr);
    logic [xlen-1:0] val;
    if (addr == 5'd0) begin
      val = '0;
    end else if (wb.we && wb.rd == addr) begin
      val = wb.data;
    end else begin
      val = regs[addr];
    end
    return val;
  endfunction

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wb.we && wb.rd != 5'd0) begin
      regs[wb.rd] <= wb.data;
    end
  end

  always_comb begin
    rs1_data = read_port(rs1_addr);
    rs2_data = read_port(rs2_addr);
    dbg_data = read_port(dbg_addr);
  end

endmodule

// ==== rtl/decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage
  import core_pkg::*;
(
  input  if_id_t          if_id,
  input  logic [xlen-1:0] rs1_data,
  input  logic [xlen-1:0] rs2_data,
  input  id_ex_t          id_ex_q,
  output logic [4:0]      rs1_addr,
  output logic [4:0]      rs2_addr,
  output id_ex_t          id_ex_d,
  output logic            load_stall
);

  logic [31:0]     instr;
  logic [6:0]      opcode;
  logic [2:0]      funct3;
  logic [4:0]      rd;
  logic            use_rs1;
  logic            use_rs2;
  logic [xlen-1:0] imm_i;
  logic [xlen-1:0] imm_s;
  logic [xlen-1:0] imm_b;
  logic [xlen-1:0] imm_u;

  // bubbles decode as a plain nop
  assign instr    = if_id.valid ? if_id.instr : nop_instr;
  assign opcode   = instr[6:0];
  assign funct3   = instr[14:12];
  assign rd       = instr[11:7];
  assign rs1_addr = instr[19:15];
  assign rs2_addr = instr[24:20];

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};

  always_comb begin
    id_ex_d         = '0;
    id_ex_d.pc      = if_id.pc;
    id_ex_d.rs1_val = rs1_data;
    id_ex_d.rs2_val = rs2_data;
    id_ex_d.rs1     = rs1_addr;
    id_ex_d.rs2     = rs2_addr;
    id_ex_d.rd      = rd;
    id_ex_d.alu_op  = alu_add;
    id_ex_d.valid   = if_id.valid;
    use_rs1         = 1'b0;
    use_rs2         = 1'b0;

    case (opcode)
      op_lui: begin
        id_ex_d.imm         = imm_u;
        id_ex_d.alu_op      = alu_passb;
        id_ex_d.alu_src_imm = 1'b1;
        id_ex_d.reg_write   = 1'b1;
      end
      op_imm: begin
        use_rs1             = 1'b1;
        id_ex_d.imm         = imm_i;
        id_ex_d.alu_src_imm = 1'b1;
        id_ex_d.reg_write   = 1'b1;
        case (funct3)
          3'b000:  id_ex_d.alu_op = alu_add;
          3'b100:  id_ex_d.alu_op = alu_xor;
          3'b110:  id_ex_d.alu_op = alu_or;
          3'b111:  id_ex_d.alu_op = alu_and;
          default: id_ex_d.reg_write = 1'b0;
        endcase
      end
      op_reg: begin
        use_rs1           = 1'b1;
        use_rs2           = 1'b1;
        id_ex_d.reg_write = 1'b1;
        case (funct3)
          3'b000:  id_ex_d.alu_op = instr[30] ? alu_sub : alu_add;
          3'b010:  id_ex_d.alu_op = alu_slt;
          3'b100:  id_ex_d.alu_op = alu_xor;
          3'b110:  id_ex_d.alu_op = alu_or;
          3'b111:  id_ex_d.alu_op = alu_and;
          default: id_ex_d.reg_write = 1'b0;
        endcase
      end
      op_load: begin
        use_rs1             = 1'b1;
        id_ex_d.imm         = imm_i;
        id_ex_d.alu_src_imm = 1'b1;
        id_ex_d.mem_read    = (funct3 == 3'b010);
        id_ex_d.reg_write   = (funct3 == 3'b010);
      end
      op_store: begin
        use_rs1             = 1'b1;
        use_rs2             = 1'b1;
        id_ex_d.imm         = imm_s;
        id_ex_d.alu_src_imm = 1'b1;
        id_ex_d.mem_write   = (funct3 == 3'b010);
      end
      op_branch: begin
        use_rs1           = 1'b1;
        use_rs2           = 1'b1;
        id_ex_d.imm       = imm_b;
        id_ex_d.branch    = (funct3 == 3'b000) || (funct3 == 3'b001);
        id_ex_d.branch_ne = (funct3 == 3'b001);
      end
      default: begin
        id_ex_d.reg_write = 1'b0;
      end
    endcase

    // results for x0 are dropped here so forwarding never sees them
    if (rd == 5'd0) begin
      id_ex_d.reg_write = 1'b0;
    end
  end

  // load in EX feeding a source of the instruction in ID
  assign load_stall = id_ex_q.valid && id_ex_q.mem_read && (id_ex_q.rd != 5'd0) &&
                      ((use_rs1 && rs1_addr == id_ex_q.rd) ||
                       (use_rs2 && rs2_addr == id_ex_q.rd));

endmodule

// ==== rtl/execute_stage.sv ====
`timescale 1ns/1ps

module execute_stage
  import core_pkg::*;
(
  input  id_ex_t          id_ex,
  input  ex_mem_t         ex_mem_q,
  input  wb_t             mem_wb_q,
  output ex_mem_t         ex_mem_d,
  output logic            branch_taken,
  output logic [xlen-1:0] branch_target
);

  logic [xlen-1:0] op_a;
  logic [xlen-1:0] rs2_fwd;
  logic [xlen-1:0] op_b;
  logic [xlen-1:0] result;
  logic            rs_equal;

  // EX/MEM is newer than MEM/WB, load data is not ready in EX/MEM
  function automatic logic [xlen-1:0] forward(logic [4:0] idx, logic [xlen-1:0] reg_val);
    logic [xlen-1:0] val;
    val = reg_val;
    if (idx != 5'd0) begin
      if (ex_mem_q.valid && ex_mem_q.reg_write && !ex_mem_q.mem_read &&
          ex_mem_q.rd == idx) begin
        val = ex_mem_q.alu_res;
      end else if (mem_wb_q.we && mem_wb_q.rd == idx) begin
        val = mem_wb_q.data;
      end
    end
    return val;
  endfunction

  always_comb begin
    op_a    = forward(id_ex.rs1, id_ex.rs1_val);
    rs2_fwd = forward(id_ex.rs2, id_ex.rs2_val);
    op_b    = id_ex.alu_src_imm ? id_ex.imm : rs2_fwd;
  end

  ////////////////////
  // alu
  ////////////////////

  always_comb begin
    case (id_ex.alu_op)
      alu_add: result = op_a + op_b;
      alu_sub: result = op_a - op_b;
      alu_and: result = op_a & op_b;
      alu_or:  result = op_a | op_b;
      alu_xor: result = op_a ^ op_b;
      alu_slt: result = {{(xlen-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      default: result = op_b;
    endcase
  end

  // beq and bne resolve here
  assign rs_equal      = (op_a == rs2_fwd);
  assign branch_taken  = id_ex.valid && id_ex.branch && (id_ex.branch_ne ? !rs_equal : rs_equal);
  assign branch_target = id_ex.pc + id_ex.imm;

  always_comb begin
    ex_mem_d.alu_res    = result;
    ex_mem_d.store_data = rs2_fwd;
    ex_mem_d.rd         = id_ex.rd;
    ex_mem_d.mem_read   = id_ex.mem_read;
    ex_mem_d.mem_write  = id_ex.mem_write;
    ex_mem_d.reg_write  = id_ex.reg_write;
    ex_mem_d.valid      = id_ex.valid;
  end

endmodule

// ==== rtl/memory_stage.sv ====
`timescale 1ns/1ps

module memory_stage
  import core_pkg::*;
(
  input  logic    clk,
  input  logic    arst_n,
  input  ex_mem_t ex_mem,
  output wb_req_t wb_req,
  input  wb_rsp_t wb_rsp,
  output logic    mem_hold,
  output wb_t     mem_wb_d
);

  logic is_mem;
  logic done;

  assign is_mem = ex_mem.valid && (ex_mem.mem_read || ex_mem.mem_write);

  // high for the cycle after ack, so stb drops once per access
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      done <= 1'b0;
    end else begin
      done <= wb_rsp.ack;
    end
  end

  // request comes straight from the held EX/MEM register
  always_comb begin
    wb_req.cyc = is_mem && !done;
    wb_req.stb = is_mem && !done;
    wb_req.we  = ex_mem.mem_write;
    wb_req.adr = ex_mem.alu_res[dmem_aw+1:2];
    wb_req.dat = ex_mem.store_data;
  end

  assign mem_hold = is_mem && !wb_rsp.ack;

  // writeback select
  always_comb begin
    mem_wb_d.we   = ex_mem.valid && ex_mem.reg_write;
    mem_wb_d.rd   = ex_mem.rd;
    mem_wb_d.data = ex_mem.mem_read ? wb_rsp.dat : ex_mem.alu_res;
  end

  a_stb_until_ack: assert property (
    @(posedge clk) disable iff (!arst_n)
    $fell(wb_req.stb) |-> $past(wb_rsp.ack)
  ) else $error("wishbone stb dropped before ack");

endmodule

// ==== rtl/data_ram.sv ====
`timescale 1ns/1ps

module data_ram
  import core_pkg::*;
(
  input  logic    clk,
  input  logic    arst_n,
  input  wb_req_t wb_req,
  output wb_rsp_t wb_rsp
);

  logic [xlen-1:0] mem [2**dmem_aw];
  logic [xlen-1:0] rdata_q;
  logic            ack_q;
  logic            access;

  // no new access in the ack cycle
  assign access = wb_req.cyc && wb_req.stb && !ack_q;

  always_ff @(posedge clk) begin
    if (access) begin
      if (wb_req.we) begin
        mem[wb_req.adr] <= wb_req.dat;
      end
      rdata_q <= mem[wb_req.adr];
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= access;
    end
  end

  assign wb_rsp.ack = ack_q;
  assign wb_rsp.dat = rdata_q;

  a_ack_after_stb: assert property (
    @(posedge clk) disable iff (!arst_n)
    wb_rsp.ack |-> $past(wb_req.stb)
  ) else $error("wishbone ack without a preceding stb");

endmodule

// ==== rtl/riscv_system.sv ====
`timescale 1ns/1ps

module riscv_system
  import core_pkg::*;
(
  input  logic               clk,
  input  logic               arst_n,
  input  logic               prog,
  input  logic               prog_we,
  input  logic [imem_aw-1:0] prog_addr,
  input  logic [xlen-1:0]    prog_data,
  input  logic               debug,
  input  logic [4:0]         debug_addr,
  output logic [xlen-1:0]    debug_data
);

  if_id_t          if_id_d;
  if_id_t          if_id_q;
  id_ex_t          id_ex_d;
  id_ex_t          id_ex_q;
  ex_mem_t         ex_mem_d;
  ex_mem_t         ex_mem_q;
  wb_t             mem_wb_d;
  wb_t             mem_wb_q;
  wb_req_t         wb_req;
  wb_rsp_t         wb_rsp;
  logic [4:0]      rs1_addr;
  logic [4:0]      rs2_addr;
  logic [xlen-1:0] rs1_data;
  logic [xlen-1:0] rs2_data;
  logic [xlen-1:0] dbg_data;
  logic [xlen-1:0] prog_rdata;
  logic [xlen-1:0] branch_target;
  logic            load_stall;
  logic            branch_taken;
  logic            mem_hold;
  logic            freeze;
  logic            stall;
  logic            redirect;

  ////////////////////
  // stall and flush
  ////////////////////

  // a frozen pipe must not lose the load or branch sitting in EX
  assign freeze   = prog || debug || mem_hold;
  assign stall    = load_stall && !freeze;
  assign redirect = branch_taken && !freeze;

  fetch_stage fetch_i (
    .clk(clk), .arst_n(arst_n), .hold(freeze || load_stall),
    .prog(prog), .prog_we(prog_we), .prog_addr(prog_addr), .prog_data(prog_data),
    .branch_taken(redirect), .branch_target(branch_target),
    .if_id(if_id_d), .prog_rdata(prog_rdata)
  );

  pipe_reg #(.payload_t(if_id_t)) if_id_reg (
    .clk(clk), .arst_n(arst_n), .hold(freeze || load_stall), .flush(prog || redirect),
    .d(if_id_d), .q(if_id_q)
  );

  regfile regfile_i (
    .clk(clk), .arst_n(arst_n),
    .rs1_addr(rs1_addr), .rs2_addr(rs2_addr), .rs1_data(rs1_data), .rs2_data(rs2_data),
    .wb(mem_wb_q), .dbg_addr(debug_addr), .dbg_data(dbg_data)
  );

  decode_stage decode_i (
    .if_id(if_id_q), .rs1_data(rs1_data), .rs2_data(rs2_data), .id_ex_q(id_ex_q),
    .rs1_addr(rs1_addr), .rs2_addr(rs2_addr), .id_ex_d(id_ex_d), .load_stall(load_stall)
  );

  pipe_reg #(.payload_t(id_ex_t)) id_ex_reg (
    .clk(clk), .arst_n(arst_n), .hold(freeze), .flush(prog || redirect || stall),
    .d(id_ex_d), .q(id_ex_q)
  );

  execute_stage execute_i (
    .id_ex(id_ex_q), .ex_mem_q(ex_mem_q), .mem_wb_q(mem_wb_q), .ex_mem_d(ex_mem_d),
    .branch_taken(branch_taken), .branch_target(branch_target)
  );

  pipe_reg #(.payload_t(ex_mem_t)) ex_mem_reg (
    .clk(clk), .arst_n(arst_n), .hold(freeze), .flush(prog),
    .d(ex_mem_d), .q(ex_mem_q)
  );

  memory_stage memory_i (
    .clk(clk), .arst_n(arst_n), .ex_mem(ex_mem_q), .wb_req(wb_req), .wb_rsp(wb_rsp),
    .mem_hold(mem_hold), .mem_wb_d(mem_wb_d)
  );

  pipe_reg #(.payload_t(wb_t)) mem_wb_reg (
    .clk(clk), .arst_n(arst_n), .hold(freeze), .flush(prog),
    .d(mem_wb_d), .q(mem_wb_q)
  );

  data_ram data_ram_i (
    .clk(clk), .arst_n(arst_n), .wb_req(wb_req), .wb_rsp(wb_rsp)
  );

  // prog shows imem, debug shows a register
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      debug_data <= '0;
    end else if (prog) begin
      debug_data <= prog_rdata;
    end else if (debug) begin
      debug_data <= dbg_data;
    end else begin
      debug_data <= '0;
    end
  end

endmodule

// ==== sim/tb_riscv_system.sv ====
`timescale 1ns/1ps

module tb_riscv_system
  import core_pkg::*;
();

  localparam int max_tests  = 8;
  localparam int max_words  = 64;
  localparam int max_checks = 32;
  // cycles per test for program load, readback and register reads
  localparam int test_slack = 50;

  logic               clk;
  logic               arst_n;
  logic               prog;
  logic               prog_we;
  logic [imem_aw-1:0] prog_addr;
  logic [xlen-1:0]    prog_data;
  logic               debug;
  logic [4:0]         debug_addr;
  logic [xlen-1:0]    debug_data;

  string       test_name   [max_tests];
  int          word_count  [max_tests];
  logic [31:0] prog_words  [max_tests][max_words];
  int          run_cycles  [max_tests];
  int          check_count [max_tests];
  logic [4:0]  check_reg   [max_tests][max_checks];
  logic [31:0] check_val   [max_tests][max_checks];
  int          num_tests;
  int          errors;
  int          passes;
  int          cycle_count;
  int          cycle_limit;
  bit          file_ok;

  riscv_system dut_i (
    .clk(clk), .arst_n(arst_n),
    .prog(prog), .prog_we(prog_we), .prog_addr(prog_addr), .prog_data(prog_data),
    .debug(debug), .debug_addr(debug_addr), .debug_data(debug_data)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #50 clk = ~clk;
    end
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
  end

  initial begin
    wait (cycle_limit > 0);
    wait (cycle_count >= cycle_limit);
    $display("timeout: tests still running after %0d cycles", cycle_limit);
    $display("FAIL: see errors above");
    $finish;
  end

  ////////////////////
  // data file
  ////////////////////

  task automatic skip_line(input int fd);
    int ch;
    ch = $fgetc(fd);
    while (ch != 10 && ch != -1) begin
      ch = $fgetc(fd);
    end
  endtask

  task automatic read_tests(output bit ok);
    int          fd;
    int          code;
    int          cur;
    int          num;
    int          reg_num;
    logic [31:0] word;
    string       tok;
    ok        = 1'b1;
    cur       = -1;
    num_tests = 0;
    fd = $fopen("sim/program_input.txt", "r");
    if (fd == 0) begin
      ok = 1'b0;
    end else begin
      while (ok && $fscanf(fd, "%s", tok) == 1) begin
        if (tok.getc(0) == "#") begin
          skip_line(fd);
        end else if (tok == "test") begin
          ok = (num_tests < max_tests);
          cur = num_tests;
          num_tests++;
          code = $fscanf(fd, "%s", tok);
          ok = ok && (code == 1);
          test_name[cur] = tok;
        end else if (cur < 0) begin
          ok = 1'b0;
        end else if (tok == "run") begin
          code = $fscanf(fd, "%d", num);
          ok = (code == 1);
          run_cycles[cur] = num;
        end else if (tok == "words") begin
          code = $fscanf(fd, "%d", num);
          ok = (code == 1) && (num <= max_words);
          word_count[cur] = num;
          for (int i = 0; ok && i < num; i++) begin
            code = $fscanf(fd, "%h", word);
            ok = (code == 1);
            prog_words[cur][i] = word;
          end
        end else if (tok == "check") begin
          code = $fscanf(fd, "%d", num);
          ok = (code == 1) && (num <= max_checks);
          check_count[cur] = num;
          for (int i = 0; ok && i < num; i++) begin
            code = $fscanf(fd, "%d", reg_num);
            ok = (code == 1);
            check_reg[cur][i] = 5'(reg_num);
            code = $fscanf(fd, "%h", word);
            ok = ok && (code == 1);
            check_val[cur][i] = word;
          end
        end else begin
          ok = 1'b0;
        end
      end
      $fclose(fd);
      ok = ok && (num_tests > 0);
    end
  endtask

  ////////////////////
  // checks and phases
  ////////////////////

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      errors++;
      $display("Fail %s expected %08h actual %08h", what, expected, actual);
    end else begin
      passes++;
      $display("Pass %s expected %08h actual %08h", what, expected, actual);
    end
  endtask

  // write every word, then read them back one cycle behind the address
  task automatic load_program(input int t);
    for (int i = 0; i < word_count[t]; i++) begin
      @(posedge clk);
      prog      <= 1'b1;
      prog_we   <= 1'b1;
      prog_addr <= imem_aw'(i);
      prog_data <= prog_words[t][i];
    end
    for (int i = 0; i <= word_count[t]; i++) begin
      @(posedge clk);
      prog_we <= 1'b0;
      if (i < word_count[t]) begin
        prog_addr <= imem_aw'(i);
      end
      @(negedge clk);
      if (i > 0) begin
        check_value($sformatf("%s imem[%0d]", test_name[t], i - 1),
                    prog_words[t][i-1], debug_data);
      end
    end
    @(posedge clk);
    prog <= 1'b0;
  endtask

  // debug_data lags debug_addr by one cycle
  task automatic read_registers(input int t);
    for (int j = 0; j <= check_count[t]; j++) begin
      @(posedge clk);
      if (j < check_count[t]) begin
        debug      <= 1'b1;
        debug_addr <= check_reg[t][j];
      end
      @(negedge clk);
      if (j > 0) begin
        check_value($sformatf("%s x%0d", test_name[t], check_reg[t][j-1]),
                    check_val[t][j-1], debug_data);
      end
    end
    @(posedge clk);
    debug <= 1'b0;
  endtask

  task automatic run_test(input int t);
    int errors_before;
    errors_before = errors;
    load_program(t);
    repeat (run_cycles[t]) begin
      @(posedge clk);
    end
    read_registers(t);
    $display("test %s finished, %0d failed checks", test_name[t], errors - errors_before);
  endtask

  initial begin
    arst_n      = 1'b0;
    prog        = 1'b0;
    prog_we     = 1'b0;
    prog_addr   = '0;
    prog_data   = '0;
    debug       = 1'b0;
    debug_addr  = '0;
    errors      = 0;
    passes      = 0;
    cycle_count = 0;
    cycle_limit = 0;
    read_tests(file_ok);
    if (!file_ok) begin
      $display("error: sim/program_input.txt is missing or malformed");
      $display("FAIL: see errors above");
      $finish;
    end else begin
      cycle_limit = test_slack * num_tests;
      for (int t = 0; t < num_tests; t++) begin
        cycle_limit += run_cycles[t];
      end
      repeat (5) begin
        @(posedge clk);
      end
      arst_n <= 1'b1;
      for (int t = 0; t < num_tests; t++) begin
        run_test(t);
      end
      $display("%0d checks passed, %0d checks failed", passes, errors);
      if (errors == 0) begin
        $display("PASS: all tests");
      end else begin
        $display("FAIL: see errors above");
      end
      $finish;
    end
  end

endmodule

// ==== riscv_system.f ====
rtl/core_pkg.sv
rtl/pipe_reg.sv
rtl/fetch_stage.sv
rtl/regfile.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/memory_stage.sv
rtl/data_ram.sv
rtl/riscv_system.sv
sim/tb_riscv_system.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        ?= tb_riscv_system
RTL_TOP    ?= riscv_system
FILELIST   ?= riscv_system.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
PASS_MSG   ?= PASS: all tests
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

# build, run, then decide pass or fail from the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== sim/program_input.txt ====
# keywords: test <name>, run <cycles>, words <count> <hex instruction words>
# check <count> followed by pairs of <register number> <hex value>
test alu_chain
run 40
words 13
00500093 00308113 002081b3 40118233 0021f2b3 0012e333 002343b3
0063a433 123454b7 fff48513 fff0c593 0015a633 00000063
check 12
1 00000005 2 00000008 3 0000000d 4 00000008 5 00000008 6 0000000d
7 00000005 8 00000001 9 12345000 10 12344fff 11 fffffffa 12 00000001

test store_load
run 60
words 12
04000093 12300113 0020a023 ff900193 0030a223 0000a203 004202b3
0040a303 406283b3 0070a423 0080a403 00000063
check 6
1 00000040 4 00000123 5 00000246 6 fffffff9 7 0000024d 8 0000024d

test branches
run 40
words 13
00100093 00100113 00700193 00700213 00208663 06300193 06300213
00309663 03700193 03700213 00308463 02a00293 00000063
check 4
1 00000001 3 00000007 4 00000007 5 0000002a

test x0_and_logic
run 40
words 10
00500013 0f000093 00f0e013 00100133 00f0e193 03c1f213 0ff24293
abcde037 00000333 00000063
check 7
0 00000000 1 000000f0 2 000000f0 3 000000ff 4 0000003c 5 000000c3 6 00000000
